/* frv_pkg.sv */
/*
 * Shared definitions for the RV32I integer pipeline.
 * Widths, opcode and funct constants, micro-ops and the stage payloads.
 */

package frv_pkg;

    localparam int XLEN = 32;                  // Data and address width

    typedef logic [XLEN-1:0] word_t;           // Data or address word
    typedef logic [4:0]      reg_addr_t;       // GPR index
    typedef logic [31:0]     instr_t;          // Raw instruction word

    // ----------------------------------------------------------------------
    // Major opcodes and funct fields of the kept instructions

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // Also ADDI
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // ----------------------------------------------------------------------
    // Micro-ops, nine of them so 4 bits wide

    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_PASS_B,                            // LUI
        UOP_BEQ,
        UOP_BNE,
        UOP_JAL
    } uop_t;

    // Decode to execute
    typedef struct packed {
        reg_addr_t rd;
        logic      rd_wen;
        uop_t      uop;
        word_t     opr_a;                      // rs1, or zero for LUI
        word_t     opr_b;                      // rs2 or immediate
        word_t     opr_c;                      // Branch or JAL offset
    } decoded_t;

    // Execute to writeback
    typedef struct packed {
        reg_addr_t rd;
        logic      rd_wen;
        word_t     wdata;
        logic      cf_taken;                   // Branch taken or JAL
        word_t     cf_target;
    } result_t;

endpackage

/* frv_stage_if.sv */
/*
 * Stage boundary between two pipeline stages.
 * A one-cycle valid level with the pc, the instruction word and a payload.
 */

`timescale 1ns/10ps

interface frv_stage_if import frv_pkg::*; #(
    parameter type payload_t = logic
) ();

    logic     valid;                           // Item present this cycle
    word_t    pc;                              // PC of the item
    instr_t   instr;                           // Carried for the trace
    payload_t data;                            // Stage specific payload

    modport source (output valid, pc, instr, data);
    modport sink   (input  valid, pc, instr, data);

endinterface

/* frv_fetch.sv */
/*
 * Fetch stage. Keeps the PC, runs the imem req/gnt and recv/ack strobes
 * with one request in flight, and registers the fetched word for decode.
 */

`timescale 1ns/10ps

module frv_fetch import frv_pkg::*; #(
    parameter word_t FRV_PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic   g_clk,
    input  logic   reset,
    input  logic   cf_req,                     // Redirect from writeback
    input  word_t  cf_target,
    output logic   imem_req,
    output word_t  imem_addr,
    input  logic   imem_gnt,
    input  logic   imem_recv,
    output logic   imem_ack,
    input  word_t  imem_rdata,
    output logic   s1_valid,
    output word_t  s1_pc,
    output instr_t s1_instr
);

    word_t pc_q;                               // Next address to request
    logic  wait_q;                             // Granted, response pending
    logic  drop_q;                             // Pending response is stale
    word_t pc_n;                               // PC after any redirect
    logic  raise;                              // Start a new request

    assign pc_n     = cf_req ? cf_target : pc_q;
    assign raise    = !imem_req && !wait_q;    // Earliest the cycle after ack
    assign imem_ack = wait_q && imem_recv;     // Always take the word

    // ----------------------------------------------------------------------
    // Request and response control

    always_ff @(posedge g_clk) begin
        if (reset) begin
            pc_q     <= FRV_PC_RESET_VALUE;
            imem_req <= 1'b0;
            wait_q   <= 1'b0;
            drop_q   <= 1'b0;
            s1_valid <= 1'b0;
        end else begin
            if (imem_req && imem_gnt) begin
                imem_req <= 1'b0;
                wait_q   <= 1'b1;
                if (cf_req || drop_q) begin
                    pc_q <= pc_n;              // Stale grant keeps the redirect
                end else begin
                    pc_q <= imem_addr + 32'd4;
                end
            end else begin
                pc_q     <= pc_n;
            end
            if (raise) begin
                imem_req <= 1'b1;
            end
            if (imem_ack) begin
                wait_q   <= 1'b0;
            end
            // A redirect orphans whatever is raised or still to return
            if (cf_req) begin
                drop_q   <= imem_req || (wait_q && !imem_recv);
            end else if (imem_ack) begin
                drop_q   <= 1'b0;
            end
            s1_valid <= imem_ack && !drop_q && !cf_req;
        end
    end

    // ----------------------------------------------------------------------
    // Address and fetched word

    always_ff @(posedge g_clk) begin
        if (raise) begin
            imem_addr <= pc_n;                 // Held until grant
        end
        if (imem_ack) begin
            s1_pc     <= imem_addr;            // Word paired with its address
            s1_instr  <= imem_rdata;
        end
    end

endmodule

/* frv_decode.sv */
/*
 * Decode stage. Splits the instruction into fields and immediates, maps it
 * to a micro-op, reads the GPRs with forwarding and registers the result.
 */

`timescale 1ns/10ps

module frv_decode import frv_pkg::*; (
    input  logic       g_clk,
    input  logic       reset,
    input  logic       s1_valid,
    input  word_t      s1_pc,
    input  instr_t     s1_instr,
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    input  word_t      rs1_rdata,
    input  word_t      rs2_rdata,
    input  logic       fwd_valid,              // Execute stage result
    input  reg_addr_t  fwd_rd,
    input  word_t      fwd_wdata,
    input  logic       gpr_wen,                // Writeback stage result
    input  reg_addr_t  gpr_rd,
    input  word_t      gpr_wdata,
    input  logic       cf_req,                 // Flush
    frv_stage_if.source s2
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    word_t      rs1_fwd;
    word_t      rs2_fwd;
    decoded_t   dec;

    assign opcode   = s1_instr[6:0];
    assign funct3   = s1_instr[14:12];
    assign funct7   = s1_instr[31:25];
    assign rs1_addr = s1_instr[19:15];
    assign rs2_addr = s1_instr[24:20];

    assign imm_i = {{20{s1_instr[31]}}, s1_instr[31:20]};
    assign imm_b = {{19{s1_instr[31]}}, s1_instr[31], s1_instr[7],
                    s1_instr[30:25], s1_instr[11:8], 1'b0};
    assign imm_j = {{11{s1_instr[31]}}, s1_instr[31], s1_instr[19:12],
                    s1_instr[20], s1_instr[30:21], 1'b0};
    assign imm_u = {s1_instr[31:12], 12'b0};

    // ----------------------------------------------------------------------
    // Operand forwarding, youngest producer first

    function automatic word_t fwd_sel(input reg_addr_t addr, input word_t rdata);
        logic nz;
        nz = |addr;                            // x0 never forwards
        if (nz && fwd_valid && fwd_rd == addr) begin
            return fwd_wdata;
        end else if (nz && gpr_wen && gpr_rd == addr) begin
            return gpr_wdata;
        end
        return rdata;
    endfunction

    always_comb begin
        rs1_fwd = fwd_sel(rs1_addr, rs1_rdata);
        rs2_fwd = fwd_sel(rs2_addr, rs2_rdata);
    end

    // ----------------------------------------------------------------------
    // Micro-op mapping, anything unknown becomes a no-write ADD

    always_comb begin
        dec.rd     = s1_instr[11:7];
        dec.rd_wen = 1'b0;
        dec.uop    = UOP_ADD;
        dec.opr_a  = rs1_fwd;
        dec.opr_b  = rs2_fwd;
        dec.opr_c  = imm_b;
        case (opcode)
            OPC_OP: begin
                dec.rd_wen = (funct7 == F7_BASE) ||
                             (funct7 == F7_SUB && funct3 == F3_ADD_SUB);
                case (funct3)
                    F3_ADD_SUB: dec.uop = (funct7 == F7_SUB) ? UOP_SUB : UOP_ADD;
                    F3_XOR:     dec.uop = UOP_XOR;
                    F3_OR:      dec.uop = UOP_OR;
                    F3_AND:     dec.uop = UOP_AND;
                    default:    dec.rd_wen = 1'b0;   // Shifts and compares
                endcase
            end
            OPC_OP_IMM: begin
                dec.rd_wen = funct3 == F3_ADD_SUB;   // ADDI only
                dec.opr_b  = imm_i;
            end
            OPC_LUI: begin
                dec.rd_wen = 1'b1;
                dec.uop    = UOP_PASS_B;
                dec.opr_a  = '0;
                dec.opr_b  = imm_u;
            end
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    dec.uop = UOP_BEQ;
                end else if (funct3 == F3_BNE) begin
                    dec.uop = UOP_BNE;
                end
            end
            OPC_JAL: begin
                dec.rd_wen = 1'b1;
                dec.uop    = UOP_JAL;
                dec.opr_c  = imm_j;
            end
            default: begin
                dec.rd_wen = 1'b0;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Decode/execute register

    always_ff @(posedge g_clk) begin
        if (reset) begin
            s2.valid <= 1'b0;
        end else begin
            s2.valid <= s1_valid && !cf_req;   // Younger than the redirect
        end
    end

    always_ff @(posedge g_clk) begin
        s2.pc    <= s1_pc;
        s2.instr <= s1_instr;
        s2.data  <= dec;
    end

endmodule

/* frv_execute.sv */
/*
 * Execute stage. ALU, branch compare and target adder. Presents its
 * unregistered result for forwarding and registers it for writeback.
 */

`timescale 1ns/10ps

module frv_execute import frv_pkg::*; (
    input  logic       g_clk,
    input  logic       reset,
    input  logic       cf_req,                 // Flush
    output logic       fwd_valid,
    output reg_addr_t  fwd_rd,
    output word_t      fwd_wdata,
    frv_stage_if.sink   s2,
    frv_stage_if.source s3
);

    word_t   alu;                              // Result for rd
    logic    eq;                               // Branch compare
    result_t res;

    always_comb begin
        case (s2.data.uop)
            UOP_ADD:    alu = s2.data.opr_a + s2.data.opr_b;
            UOP_SUB:    alu = s2.data.opr_a - s2.data.opr_b;
            UOP_AND:    alu = s2.data.opr_a & s2.data.opr_b;
            UOP_OR:     alu = s2.data.opr_a | s2.data.opr_b;
            UOP_XOR:    alu = s2.data.opr_a ^ s2.data.opr_b;
            UOP_PASS_B: alu = s2.data.opr_b;
            UOP_JAL:    alu = s2.pc + 32'd4;   // Link value
            default:    alu = '0;              // Branches write nothing
        endcase
    end

    assign eq = s2.data.opr_a == s2.data.opr_b;

    assign res.rd        = s2.data.rd;
    assign res.rd_wen    = s2.data.rd_wen;
    assign res.wdata     = alu;
    assign res.cf_taken  = (s2.data.uop == UOP_BEQ &&  eq) ||
                           (s2.data.uop == UOP_BNE && !eq) ||
                           (s2.data.uop == UOP_JAL);
    assign res.cf_target = s2.pc + s2.data.opr_c;

    // Forwarding view of the result being computed
    assign fwd_valid = s2.valid && s2.data.rd_wen;
    assign fwd_rd    = s2.data.rd;
    assign fwd_wdata = alu;

    // ----------------------------------------------------------------------
    // Execute/writeback register

    always_ff @(posedge g_clk) begin
        if (reset) begin
            s3.valid <= 1'b0;
        end else begin
            s3.valid <= s2.valid && !cf_req;
        end
    end

    always_ff @(posedge g_clk) begin
        s3.pc    <= s2.pc;
        s3.instr <= s2.instr;
        s3.data  <= res;
    end

endmodule

/* frv_writeback.sv */
/*
 * Writeback stage. Writes the GPRs, raises the control flow change that
 * redirects fetch and flushes younger stages, and registers the trace.
 */

`timescale 1ns/10ps

module frv_writeback import frv_pkg::*; (
    input  logic       g_clk,
    input  logic       reset,
    output logic       gpr_wen,
    output reg_addr_t  gpr_rd,
    output word_t      gpr_wdata,
    output logic       cf_req,
    output word_t      cf_target,
    output logic       trs_valid,
    output word_t      trs_pc,
    output instr_t     trs_instr,
    output reg_addr_t  trs_rd,
    output word_t      trs_wdata,
    frv_stage_if.sink   s3
);

    // No write to x0
    assign gpr_wen   = s3.valid && s3.data.rd_wen && |s3.data.rd;
    assign gpr_rd    = s3.data.rd;
    assign gpr_wdata = s3.data.wdata;

    // Single flush source for the whole pipe
    assign cf_req    = s3.valid && s3.data.cf_taken;
    assign cf_target = s3.data.cf_target;

    // ----------------------------------------------------------------------
    // Retirement trace, one cycle after writeback

    always_ff @(posedge g_clk) begin
        if (reset) begin
            trs_valid <= 1'b0;
        end else begin
            trs_valid <= s3.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        trs_pc    <= s3.pc;
        trs_instr <= s3.instr;
        trs_rd    <= gpr_wen ? gpr_rd    : '0; // Zero when nothing written
        trs_wdata <= gpr_wen ? gpr_wdata : '0;
    end

endmodule

/* frv_gprs.sv */
/*
 * General purpose registers x1 to x31, x0 reads as zero.
 * Two combinational reads, one write port.
 */

`timescale 1ns/10ps

module frv_gprs import frv_pkg::*; (
    input  logic      g_clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    output word_t     rs1_data,
    input  reg_addr_t rs2_addr,
    output word_t     rs2_data,
    input  logic      rd_wen,
    input  reg_addr_t rd_addr,
    input  word_t     rd_data
);

    word_t regs [1:31];                        // No storage for x0

    // Old value during a write cycle, decode forwards around it
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

endmodule

/* frv_pipeline.sv */
/*
 * Top level of the four stage RV32I pipeline.
 * Fetch, decode, execute and writeback around the GPR file.
 */

`timescale 1ns/10ps

module frv_pipeline import frv_pkg::*; #(
    parameter word_t FRV_PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic      g_clk,
    input  logic      reset,
    output logic      imem_req,                // Instruction fetch bus
    output word_t     imem_addr,
    input  logic      imem_gnt,
    input  logic      imem_recv,
    output logic      imem_ack,
    input  word_t     imem_rdata,
    output logic      trs_valid,               // Retirement trace
    output word_t     trs_pc,
    output instr_t    trs_instr,
    output reg_addr_t trs_rd,
    output word_t     trs_wdata
);

    logic      cf_req;                         // Redirect and flush
    word_t     cf_target;
    logic      s1_valid;                       // Fetch to decode
    word_t     s1_pc;
    instr_t    s1_instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    logic      fwd_valid;                      // Execute forward
    reg_addr_t fwd_rd;
    word_t     fwd_wdata;
    logic      gpr_wen;                        // Writeback forward and write
    reg_addr_t gpr_rd;
    word_t     gpr_wdata;

    frv_stage_if #(.payload_t(decoded_t)) s2_if ();
    frv_stage_if #(.payload_t(result_t))  s3_if ();

    // ----------------------------------------------------------------------
    // Stages

    frv_fetch #(
        .FRV_PC_RESET_VALUE(FRV_PC_RESET_VALUE)
    ) i_fetch (
        .g_clk, .reset, .cf_req, .cf_target,
        .imem_req, .imem_addr, .imem_gnt, .imem_recv, .imem_ack, .imem_rdata,
        .s1_valid, .s1_pc, .s1_instr
    );

    frv_decode i_decode (
        .g_clk, .reset, .s1_valid, .s1_pc, .s1_instr,
        .rs1_addr, .rs2_addr, .rs1_rdata, .rs2_rdata,
        .fwd_valid, .fwd_rd, .fwd_wdata,
        .gpr_wen, .gpr_rd, .gpr_wdata, .cf_req,
        .s2 (s2_if.source)
    );

    frv_execute i_execute (
        .g_clk, .reset, .cf_req,
        .fwd_valid, .fwd_rd, .fwd_wdata,
        .s2 (s2_if.sink),
        .s3 (s3_if.source)
    );

    frv_writeback i_writeback (
        .g_clk, .reset, .gpr_wen, .gpr_rd, .gpr_wdata, .cf_req, .cf_target,
        .trs_valid, .trs_pc, .trs_instr, .trs_rd, .trs_wdata,
        .s3 (s3_if.sink)
    );

    frv_gprs i_gprs (
        .g_clk, .reset,
        .rs1_addr, .rs1_data (rs1_rdata),
        .rs2_addr, .rs2_data (rs2_rdata),
        .rd_wen  (gpr_wen),
        .rd_addr (gpr_rd),
        .rd_data (gpr_wdata)
    );

endmodule

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset source.
 * 20 ns clock, reset held high for the first 10 cycles.
 */

`timescale 1ns/10ps

module tb_clock_gen (
    output logic g_clk,
    output logic reset
);

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;                // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge g_clk);
        reset <= 1'b0;                             // Released on an edge
    end

endmodule

/* frv_pipeline_assertions.sv */
/*
 * Concurrent checks on the pipeline top-level ports.
 * Fetch bus request/response rules and trace sanity.
 */

`timescale 1ns/10ps

module frv_pipeline_assertions import frv_pkg::*; (
    input logic  g_clk,
    input logic  reset,
    input logic  imem_req,
    input word_t imem_addr,
    input logic  imem_gnt,
    input logic  imem_recv,
    input logic  imem_ack,
    input logic  trs_valid,
    input word_t trs_pc
);

    int fail_count = 0;                            // Count of failed checks

    // Request and address held until granted
    req_stable : assert property (@(posedge g_clk) disable iff (reset)
        imem_req && !imem_gnt |=> imem_req && $stable(imem_addr))
        else begin
            fail_count++;
            $error("imem request dropped or address changed before grant");
        end

    ack_with_recv : assert property (@(posedge g_clk) disable iff (reset)
        imem_ack == imem_recv)                     // Word taken the cycle it arrives
        else begin
            fail_count++;
            $error("imem_ack does not follow imem_recv");
        end

    trace_quiet_in_reset : assert property (@(posedge g_clk)
        $past(reset) |-> !trs_valid)
        else begin
            fail_count++;
            $error("trs_valid high during reset");
        end

    trace_pc_aligned : assert property (@(posedge g_clk) disable iff (reset)
        trs_valid |-> trs_pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("trs_pc not word aligned");
        end

endmodule

bind frv_pipeline frv_pipeline_assertions u_assertions (.*);

/* tb_frv_pipeline.sv */
/*
 * Testbench for the RV32I pipeline. Builds a program image, serves it over
 * the imem bus with random delays and checks the retirement trace against
 * a reference ISS stepping the same program.
 */

`timescale 1ns/10ps

module tb_frv_pipeline import frv_pkg::*;;

    localparam word_t PC_RESET = 32'h8000_0000;     // Same as the DUT default
    localparam int    PROG_MAX = 64;

    logic g_clk;
    logic reset;
    logic imem_req, imem_ack, trs_valid;
    word_t imem_addr, trs_pc, trs_wdata;
    instr_t trs_instr;
    reg_addr_t trs_rd;
    logic  imem_gnt   = 1'b0;
    logic  imem_recv  = 1'b0;
    word_t imem_rdata = '0;

    instr_t prog [0:PROG_MAX-1];                   // Program image
    int     prog_len;
    word_t  iss_regs [0:31];                       // Reference register state
    word_t  exp_pc [$];
    instr_t exp_instr [$];
    reg_addr_t exp_rd [$];
    word_t  exp_wdata [$];
    int     limit;
    int     retired = 0;
    logic   done = 1'b0;

    tb_clock_gen u_clk (.g_clk, .reset);

    frv_pipeline #(.FRV_PC_RESET_VALUE(PC_RESET)) DUT (.*);

    // ------------------------------------------------------------------
    // Instruction encoders

    function automatic instr_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, reg_addr_t rd);
        return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endtask

    // ADDI x0 whose immediate folds in every address bit
    function automatic instr_t fill_word(input word_t addr);
        logic [11:0] imm;
        imm = addr[31:20] ^ addr[19:8] ^ {addr[7:0], 4'h0};
        return {imm, 5'd0, 3'b000, 5'd0, OPC_OP_IMM};
    endfunction

    function automatic instr_t fetch_word(input word_t addr);
        word_t idx;
        idx = (addr - PC_RESET) >> 2;
        if (idx < prog_len) begin
            return prog[idx];
        end
        return fill_word(addr);                    // Outside the program
    endfunction

    // ------------------------------------------------------------------
    // Reference ISS, one instruction per call

    function automatic void iss_step(input word_t pc, output word_t next_pc,
                                     output reg_addr_t rd_o, output word_t wd_o);
        instr_t ins;
        logic   wr;
        word_t  a, b, res;
        ins = fetch_word(pc);
        a = iss_regs[ins[19:15]];
        b = iss_regs[ins[24:20]];
        wr = 1'b0;
        res = '0;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin
                if (ins[31:25] == 7'h00 || (ins[31:25] == 7'h20 && ins[14:12] == 3'd0)) begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'd0: res = ins[30] ? a - b : a + b;
                        3'd4: res = a ^ b;
                        3'd6: res = a | b;
                        3'd7: res = a & b;
                        default: wr = 1'b0;    // Shifts, compares not kept
                    endcase
                end
            end
            7'b0010011: begin
                wr = ins[14:12] == 3'd0;
                res = a + {{20{ins[31]}}, ins[31:20]};
            end
            7'b0110111: begin
                wr = 1'b1;
                res = {ins[31:12], 12'h000};
            end
            7'b1100011: begin
                if ((ins[14:12] == 3'd0 && a == b) || (ins[14:12] == 3'd1 && a != b)) begin
                    next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                    ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                wr = 1'b1;
                res = pc + 32'd4;              // Link
                next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                ins[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            iss_regs[ins[11:7]] = res;
            rd_o = ins[11:7];
            wd_o = res;
        end else begin
            rd_o = '0;
            wd_o = '0;
        end
    endfunction

    // ------------------------------------------------------------------
    // Checks

    task automatic fail_value(input string name, input string e, input string a);
        $display("Error: %s expected %s actual %s", name, e, a);
        $display(">>> FAIL");
        $fatal(1, "Mismatch in %s", name);
    endtask

    task automatic check_word(input string name, input word_t e, input word_t a);
        if (e !== a) fail_value(name, $sformatf("%h", e), $sformatf("%h", a));
    endtask

    task automatic check_instr(input string name, input instr_t e, input instr_t a);
        if (e !== a) fail_value(name, $sformatf("%h", e), $sformatf("%h", a));
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t e, input reg_addr_t a);
        if (e !== a) fail_value(name, $sformatf("%0d", e), $sformatf("%0d", a));
    endtask

    // ------------------------------------------------------------------
    // imem model, random grant and response delay

    int    gnt_wait = 0;
    int    rsp_wait = 0;
    logic  pend = 1'b0;
    word_t pend_addr = '0;

    always @(posedge g_clk) begin
        if (reset) begin
            imem_gnt  <= 1'b0;
            imem_recv <= 1'b0;
            pend      <= 1'b0;
            gnt_wait  <= $urandom_range(3, 0);
        end else begin
            if (imem_req && !imem_gnt) begin
                if (gnt_wait == 0) begin
                    imem_gnt <= 1'b1;
                    gnt_wait <= $urandom_range(3, 0);
                end else begin
                    gnt_wait <= gnt_wait - 1;
                end
            end else begin
                imem_gnt <= 1'b0;
            end
            if (imem_req && imem_gnt) begin        // Request accepted here
                pend      <= 1'b1;
                pend_addr <= imem_addr;
                rsp_wait  <= $urandom_range(3, 0);
            end
            if (pend && !imem_recv) begin
                if (rsp_wait == 0) begin
                    imem_recv  <= 1'b1;
                    imem_rdata <= fetch_word(pend_addr);
                end else begin
                    rsp_wait <= rsp_wait - 1;
                end
            end
            if (imem_recv && imem_ack) begin
                imem_recv <= 1'b0;
                pend      <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Compare process on the retirement trace

    always @(posedge g_clk) begin
        if (!reset && trs_valid && !done) begin
            check_word($sformatf("retire %0d pc", retired), exp_pc[retired], trs_pc);
            check_instr($sformatf("retire %0d instr", retired), exp_instr[retired], trs_instr);
            check_reg_addr($sformatf("retire %0d rd", retired), exp_rd[retired], trs_rd);
            check_word($sformatf("retire %0d wdata", retired), exp_wdata[retired], trs_wdata);
            retired++;
            if (retired == exp_pc.size()) done <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Program build, expected stream and run control

    initial begin
        word_t pc, npc, wd;
        reg_addr_t rd;
        int cycles;
        void'($urandom(20));
        prog_len = 0;
        for (int i = 0; i < 32; i++) iss_regs[i] = '0;
        // Arithmetic on independent registers
        for (int i = 1; i <= 8; i++) emit(enc_i(12'($urandom), 5'd0, 5'(i)));
        for (int i = 0; i < 6; i++) begin
            int sel;
            sel = $urandom_range(4, 0);
            case (sel)
                0: emit(enc_r(7'h00, 5'($urandom_range(8, 1)), 5'($urandom_range(8, 1)), 3'd0, 5'(10 + i)));
                1: emit(enc_r(7'h20, 5'($urandom_range(8, 1)), 5'($urandom_range(8, 1)), 3'd0, 5'(10 + i)));
                2: emit(enc_r(7'h00, 5'($urandom_range(8, 1)), 5'($urandom_range(8, 1)), 3'd4, 5'(10 + i)));
                3: emit(enc_r(7'h00, 5'($urandom_range(8, 1)), 5'($urandom_range(8, 1)), 3'd6, 5'(10 + i)));
                default: emit(enc_r(7'h00, 5'($urandom_range(8, 1)), 5'($urandom_range(8, 1)), 3'd7, 5'(10 + i)));
            endcase
        end
        emit({20'($urandom) | 20'h1, 5'd9, OPC_LUI});   // Nonzero x9
        // Dependent chains at distance 1, 2 and 3
        emit(enc_i(12'h005, 5'd1, 5'd16));
        emit(enc_r(7'h00, 5'd16, 5'd16, 3'd0, 5'd17));
        emit(enc_r(7'h00, 5'd17, 5'd16, 3'd4, 5'd18));
        emit(enc_r(7'h20, 5'd18, 5'd16, 3'd0, 5'd19));
        emit(enc_r(7'h00, 5'd17, 5'd19, 3'd6, 5'd20));
        // Writes to x0, then reads of it
        emit(enc_i(12'h04d, 5'd1, 5'd0));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd0));
        emit(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd21));
        // Branches and JAL with flushed shadows
        emit(enc_b(13'd12, 5'd1, 5'd1, 3'd0));     // Taken BEQ
        emit(enc_i(12'h001, 5'd0, 5'd22));
        emit(enc_i(12'h002, 5'd0, 5'd23));
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'd1));      // Not taken BNE
        emit(enc_i(12'h003, 5'd0, 5'd24));
        emit(enc_b(13'd12, 5'd9, 5'd0, 3'd1));     // Taken BNE
        emit(enc_i(12'h004, 5'd0, 5'd22));
        emit(enc_i(12'h005, 5'd0, 5'd23));
        emit(enc_j(21'd12, 5'd25));
        emit(enc_i(12'h006, 5'd0, 5'd22));
        emit(enc_i(12'h007, 5'd0, 5'd23));
        emit(enc_r(7'h00, 5'd0, 5'd25, 3'd0, 5'd26)); // Uses the link at once
        emit(enc_j(21'd0, 5'd0));                  // Park
        // Expected retirement stream up to the first self loop
        pc = PC_RESET;
        for (int n = 0; n < 1000; n++) begin
            exp_pc.push_back(pc);
            exp_instr.push_back(fetch_word(pc));
            iss_step(pc, npc, rd, wd);
            exp_rd.push_back(rd);
            exp_wdata.push_back(wd);
            if (npc == pc) break;
            pc = npc;
        end
        limit = exp_pc.size() * 12 + 200;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge g_clk);
            cycles++;
            if (DUT.u_assertions.fail_count != 0) begin
                $display("A bound assertion on the DUT ports failed");
                $display(">>> FAIL");
                $fatal(1, "Assertion failure");
            end
        end
        if (done) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired, exp_pc.size());
            $display(">>> FAIL");
            $fatal(1, "Run did not complete");
        end
    end

endmodule

/* list.f */
frv_pkg.sv
frv_stage_if.sv
frv_fetch.sv
frv_decode.sv
frv_execute.sv
frv_writeback.sv
frv_gprs.sv
frv_pipeline.sv
tb_clock_gen.sv
frv_pipeline_assertions.sv
tb_frv_pipeline.sv

/* run_verilator.sh */
#!/bin/sh
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_frv_pipeline -o sim_frv

out=$(./obj_dir/sim_frv 2>&1 || true)
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
else
    exit 1
fi
